/* all.f */
+incdir+include
logic/isaPkg.sv
logic/tagPkg.sv
logic/slotPool.sv
logic/renameTable.sv
logic/dispatchControl.sv
logic/dispatchUnit.sv
dv/dispatchUnit_props.sv
dv/dispatchUnitTb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --assert --top-module dispatchUnitTb -f all.f -o simv
./obj_dir/simv

/* dv/dispatchUnitTb.sv */
`timescale 1ns/1ns
`include "dispatch_params.svh"

module dispatchUnitTb;
    import isaPkg::*;
    import tagPkg::*;

    typedef logic [`RS_ALU_SIZE-1:0] aluMaskT;
    typedef logic [`RS_LS_SIZE-1:0]  lsMaskT;

    logic                   clk;
    logic                   rstN;
    logic                   instrValid;
    instrWordT              instrWord;
    logic                   stall;
    logic                   aluRelease;
    tagT                    aluReleaseTag;
    logic                   lsRelease;
    tagT                    lsReleaseTag;
    logic                   cdbValid;
    tagT                    cdbTag;
    logic [`DATA_WIDTH-1:0] cdbData;
    logic                   aluIssue;
    logic                   lsIssue;
    opcodeT                 issueOp;
    tagT                    issueTag;
    tagT                    issueTagA;
    tagT                    issueTagB;
    logic [`DATA_WIDTH-1:0] issueDataA;
    logic [`DATA_WIDTH-1:0] issueDataB;

    // reference model of the rename table and both pools
    tagT                    modelTag   [`REG_COUNT] = '{default: NO_TAG};
    logic [`DATA_WIDTH-1:0] modelValue [`REG_COUNT] = '{default: '0};
    aluMaskT                aluBusy = '0;
    lsMaskT                 lsBusy = '0;
    logic                   accepted;
    int                     seed;
    opcodeT                 opList [7] = '{OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR,
                                           OP_LOAD, OP_STORE};

    dispatchUnit i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic abortRun(string msg);
        $display("%s", msg);
        $display("Result: FAILED");
        $fatal(1);
    endtask

    task automatic checkValue(string name, logic [31:0] expected, logic [31:0] actual);
        assert (actual === expected)
            else abortRun($sformatf("** Error at %0t ns: %s expected %h, actual %h",
                                    $time, name, expected, actual));
    endtask

    function automatic int firstFree(logic [7:0] busyBits, int count);
        for (int i = 0; i < count; i++) begin
            if (!busyBits[i])
                return i;
        end
        return -1;
    endfunction

    // alu: a = rd, b = rs1, c = rs2; memory: a = data reg, b = base, c = offset
    function automatic instrWordT makeWord(opcodeT op, logic [4:0] a, logic [4:0] b,
                                           logic [4:0] c);
        instrWordT w;
        if (op == OP_LOAD || op == OP_STORE)
            w.memView = '{op, a, b, {13'd0, c}};
        else
            w.aluView = '{op, a, b, c, 13'd0};
        return w;
    endfunction

    // one clock of prediction, model update and issue check
    task automatic runCycle();
        opcodeT                 op;
        logic                   memOp;
        logic [4:0]             nameA;
        logic [4:0]             nameB;
        logic [4:0]             dest;
        int                     slot;
        tagT                    newTag;
        tagT                    tagA;
        tagT                    tagB;
        logic [`DATA_WIDTH-1:0] dataA;
        logic [`DATA_WIDTH-1:0] dataB;
        #1;
        op = instrWord.aluView.op;
        memOp = (op == OP_LOAD) || (op == OP_STORE);
        if (memOp) begin
            nameA = instrWord.memView.baseReg;
            nameB = (op == OP_STORE) ? instrWord.memView.dataReg : 5'd0;
            dest = (op == OP_STORE) ? 5'd0 : instrWord.memView.dataReg;
            slot = firstFree(8'(lsBusy), `RS_LS_SIZE);
            newTag = LS_TAG_BASE + tagT'(slot);
        end else begin
            nameA = instrWord.aluView.rs1;
            nameB = instrWord.aluView.rs2;
            dest = instrWord.aluView.rd;
            slot = firstFree(8'(aluBusy), `RS_ALU_SIZE);
            newTag = ALU_TAG_BASE + tagT'(slot);
        end
        tagA = modelTag[nameA];
        dataA = modelValue[nameA];
        tagB = modelTag[nameB];
        dataB = modelValue[nameB];
        // result on the bus this cycle is forwarded
        if (cdbValid && cdbTag != NO_TAG && tagA == cdbTag) begin
            tagA = NO_TAG;
            dataA = cdbData;
        end
        if (cdbValid && cdbTag != NO_TAG && tagB == cdbTag) begin
            tagB = NO_TAG;
            dataB = cdbData;
        end
        accepted = instrValid && (slot >= 0);
        checkValue("stall", 32'(instrValid && !accepted), 32'(stall));
        @(posedge clk);
        if (accepted && memOp)
            lsBusy = lsBusy | (lsMaskT'(1) << slot);
        if (accepted && !memOp)
            aluBusy = aluBusy | (aluMaskT'(1) << slot);
        if (aluRelease)
            aluBusy = aluBusy & ~(aluMaskT'(1) << (aluReleaseTag - ALU_TAG_BASE));
        if (lsRelease)
            lsBusy = lsBusy & ~(lsMaskT'(1) << (lsReleaseTag - LS_TAG_BASE));
        // a rename beats a broadcast to the same register
        for (int r = 1; r < `REG_COUNT; r++) begin
            if (accepted && int'(dest) == r) begin
                modelTag[r] = newTag;
            end else if (cdbValid && cdbTag != NO_TAG && modelTag[r] == cdbTag) begin
                modelValue[r] = cdbData;
                modelTag[r] = NO_TAG;
            end
        end
        #2;
        checkValue("aluIssue", 32'(accepted && !memOp), 32'(aluIssue));
        checkValue("lsIssue", 32'(accepted && memOp), 32'(lsIssue));
        if (accepted) begin
            checkValue("issueOp", 32'(op), 32'(issueOp));
            checkValue("issueTag", 32'(newTag), 32'(issueTag));
            checkValue("issueTagA", 32'(tagA), 32'(issueTagA));
            checkValue("issueTagB", 32'(tagB), 32'(issueTagB));
            checkValue("issueDataA", dataA, issueDataA);
            checkValue("issueDataB", dataB, issueDataB);
        end
        aluRelease = 1'b0;
        lsRelease = 1'b0;
        cdbValid = 1'b0;
        if (accepted)
            instrValid = 1'b0;
    endtask

    task automatic waitAccept(int maxCycles);
        runCycle();
        for (int n = 0; n < maxCycles && !accepted; n++) begin
            runCycle();
        end
        if (!accepted)
            abortRun("instruction was never accepted, stall stayed high");
    endtask

    task automatic sendWord(instrWordT word, int maxCycles);
        instrValid = 1'b1;
        instrWord = word;
        waitAccept(maxCycles);
    endtask

    initial begin
        logic [31:0] rnd;
        opcodeT      op;
        seed = 32'h7d94_69a8;
        rstN = 1'b0;
        instrValid = 1'b0;
        instrWord = '0;
        aluRelease = 1'b0;
        aluReleaseTag = NO_TAG;
        lsRelease = 1'b0;
        lsReleaseTag = NO_TAG;
        cdbValid = 1'b0;
        cdbTag = NO_TAG;
        cdbData = '0;
        repeat (4) @(posedge clk);
        #2;
        rstN = 1'b1;
        runCycle();

        // producer, then a consumer waiting on tag 1
        sendWord(makeWord(OP_ADD, 5'd5, 5'd1, 5'd2), 4);
        sendWord(makeWord(OP_SUB, 5'd6, 5'd5, 5'd3), 4);
        cdbValid = 1'b1;
        cdbTag = ALU_TAG_BASE;
        cdbData = $random(seed);
        sendWord(makeWord(OP_XOR, 5'd7, 5'd5, 5'd6), 4);
        sendWord(makeWord(OP_OR, 5'd8, 5'd5, 5'd0), 4);
        // r6 renamed again, so the old tag 2 must not resolve it
        sendWord(makeWord(OP_AND, 5'd6, 5'd7, 5'd8), 4);
        cdbValid = 1'b1;
        cdbTag = ALU_TAG_BASE + 4'd1;
        cdbData = $random(seed);
        sendWord(makeWord(OP_ADD, 5'd9, 5'd6, 5'd6), 4);
        sendWord(makeWord(OP_ADD, 5'd0, 5'd6, 5'd0), 4);
        sendWord(makeWord(OP_SUB, 5'd10, 5'd0, 5'd0), 4);
        // alu pool full now, memory words still go
        sendWord(makeWord(OP_LOAD, 5'd11, 5'd5, 5'd3), 4);
        sendWord(makeWord(OP_STORE, 5'd11, 5'd10, 5'd1), 4);
        instrValid = 1'b1;
        instrWord = makeWord(OP_XOR, 5'd12, 5'd11, 5'd7);
        runCycle();
        aluRelease = 1'b1;
        aluReleaseTag = ALU_TAG_BASE + 4'd3;
        waitAccept(4);

        // random mix, a full pool always gets one release
        for (int n = 0; n < 200; n++) begin
            rnd = $random(seed);
            op = opList[rnd[2:0] % 3'd7];
            aluRelease = aluBusy[rnd[26:24]] && (&aluBusy || rnd[18]);
            aluReleaseTag = ALU_TAG_BASE + tagT'(rnd[26:24]);
            lsRelease = lsBusy[rnd[25:24]] && (&lsBusy || rnd[19]);
            lsReleaseTag = LS_TAG_BASE + tagT'(rnd[25:24]);
            cdbValid = rnd[20];
            cdbTag = tagT'(rnd[31:28]);
            cdbData = $random(seed);
            sendWord(makeWord(op, rnd[7:3], rnd[12:8], rnd[17:13]), 4);
        end
        $display("Result: PASSED");
        $finish;
    end

endmodule

/* dv/dispatchUnit_props.sv */
`timescale 1ns/1ns

module dispatchUnitProps (
    input logic        clk,
    input logic        rstN,
    input logic        instrValid,
    input logic        stall,
    input logic        aluIssue,
    input logic        lsIssue,
    input tagPkg::tagT issueTag
);
    import tagPkg::*;

    logic accept;

    assign accept = instrValid && !stall;

    oneStation: assert property (@(posedge clk) disable iff (!rstN)
        !(aluIssue && lsIssue))
        else $error("aluIssue and lsIssue high in the same cycle");

    aluTagRange: assert property (@(posedge clk) disable iff (!rstN)
        aluIssue |-> (issueTag >= ALU_TAG_BASE && issueTag <= ALU_TAG_LAST))
        else $error("ALU issue tag %0d out of range", issueTag);

    lsTagRange: assert property (@(posedge clk) disable iff (!rstN)
        lsIssue |-> (issueTag >= LS_TAG_BASE && issueTag <= LS_TAG_LAST))
        else $error("load/store issue tag %0d out of range", issueTag);

    // issue follows an accepted word by one cycle, and only then
    issueAfterAccept: assert property (@(posedge clk) disable iff (!rstN)
        (aluIssue || lsIssue) == $past(accept))
        else $error("issue strobe does not match the word accepted a cycle earlier");

    stallNeedsValid: assert property (@(posedge clk) disable iff (!rstN)
        stall |-> instrValid)
        else $error("stall high without instrValid");

endmodule

bind dispatchUnit dispatchUnitProps props (
    .clk,
    .rstN,
    .instrValid,
    .stall,
    .aluIssue,
    .lsIssue,
    .issueTag
);

/* logic/dispatchUnit.sv */
`timescale 1ns/1ns
`include "dispatch_params.svh"

module dispatchUnit (
    input  logic                   clk,
    input  logic                   rstN,

    input  logic                   instrValid,
    input  isaPkg::instrWordT      instrWord,
    output logic                   stall,

    input  logic                   aluRelease,
    input  tagPkg::tagT            aluReleaseTag,
    input  logic                   lsRelease,
    input  tagPkg::tagT            lsReleaseTag,

    input  logic                   cdbValid,
    input  tagPkg::tagT            cdbTag,
    input  logic [`DATA_WIDTH-1:0] cdbData,

    output logic                   aluIssue,
    output logic                   lsIssue,
    output isaPkg::opcodeT         issueOp,
    output tagPkg::tagT            issueTag,
    output tagPkg::tagT            issueTagA,
    output tagPkg::tagT            issueTagB,
    output logic [`DATA_WIDTH-1:0] issueDataA,
    output logic [`DATA_WIDTH-1:0] issueDataB
);
    import tagPkg::*;

    logic                       aluFreeValid;
    tagT                        aluFreeTag;
    logic                       aluAlloc;
    logic                       lsFreeValid;
    tagT                        lsFreeTag;
    logic                       lsAlloc;

    logic [`REG_NAME_WIDTH-1:0] readNameA;
    logic [`REG_NAME_WIDTH-1:0] readNameB;
    tagT                        readTagA;
    tagT                        readTagB;
    logic [`DATA_WIDTH-1:0]     readDataA;
    logic [`DATA_WIDTH-1:0]     readDataB;

    logic                       renameEn;
    logic [`REG_NAME_WIDTH-1:0] renameReg;
    tagT                        renameTag;

    slotPool #(
        .entryCount(`RS_ALU_SIZE),
        .tagBase(ALU_TAG_BASE)
    ) aluPool (
        .clk(clk),
        .rstN(rstN),
        .alloc(aluAlloc),
        .releaseEn(aluRelease),
        .releaseTag(aluReleaseTag),
        .freeValid(aluFreeValid),
        .freeTag(aluFreeTag)
    );

    slotPool #(
        .entryCount(`RS_LS_SIZE),
        .tagBase(LS_TAG_BASE)
    ) lsPool (
        .clk(clk),
        .rstN(rstN),
        .alloc(lsAlloc),
        .releaseEn(lsRelease),
        .releaseTag(lsReleaseTag),
        .freeValid(lsFreeValid),
        .freeTag(lsFreeTag)
    );

    renameTable renameTable (
        .clk(clk),
        .rstN(rstN),
        .readNameA(readNameA),
        .readNameB(readNameB),
        .readTagA(readTagA),
        .readTagB(readTagB),
        .readDataA(readDataA),
        .readDataB(readDataB),
        .renameEn(renameEn),
        .renameReg(renameReg),
        .renameTag(renameTag),
        .cdbValid(cdbValid),
        .cdbTag(cdbTag),
        .cdbData(cdbData)
    );

    dispatchControl dispatchControl (
        .clk(clk),
        .rstN(rstN),
        .instrValid(instrValid),
        .instrWord(instrWord),
        .stall(stall),
        .aluFreeValid(aluFreeValid),
        .aluFreeTag(aluFreeTag),
        .lsFreeValid(lsFreeValid),
        .lsFreeTag(lsFreeTag),
        .aluAlloc(aluAlloc),
        .lsAlloc(lsAlloc),
        .readNameA(readNameA),
        .readNameB(readNameB),
        .readTagA(readTagA),
        .readTagB(readTagB),
        .readDataA(readDataA),
        .readDataB(readDataB),
        .renameEn(renameEn),
        .renameReg(renameReg),
        .renameTag(renameTag),
        .cdbValid(cdbValid),
        .cdbTag(cdbTag),
        .cdbData(cdbData),
        .aluIssue(aluIssue),
        .lsIssue(lsIssue),
        .issueOp(issueOp),
        .issueTag(issueTag),
        .issueTagA(issueTagA),
        .issueTagB(issueTagB),
        .issueDataA(issueDataA),
        .issueDataB(issueDataB)
    );

endmodule

/* logic/dispatchControl.sv */
`timescale 1ns/1ns
`include "dispatch_params.svh"

module dispatchControl (
    input  logic                       clk,
    input  logic                       rstN,

    input  logic                       instrValid,
    input  isaPkg::instrWordT          instrWord,
    output logic                       stall,

    input  logic                       aluFreeValid,
    input  tagPkg::tagT                aluFreeTag,
    input  logic                       lsFreeValid,
    input  tagPkg::tagT                lsFreeTag,
    output logic                       aluAlloc,
    output logic                       lsAlloc,

    output logic [`REG_NAME_WIDTH-1:0] readNameA,
    output logic [`REG_NAME_WIDTH-1:0] readNameB,
    input  tagPkg::tagT                readTagA,
    input  tagPkg::tagT                readTagB,
    input  logic [`DATA_WIDTH-1:0]     readDataA,
    input  logic [`DATA_WIDTH-1:0]     readDataB,

    output logic                       renameEn,
    output logic [`REG_NAME_WIDTH-1:0] renameReg,
    output tagPkg::tagT                renameTag,

    input  logic                       cdbValid,
    input  tagPkg::tagT                cdbTag,
    input  logic [`DATA_WIDTH-1:0]     cdbData,

    output logic                       aluIssue,
    output logic                       lsIssue,
    output isaPkg::opcodeT             issueOp,
    output tagPkg::tagT                issueTag,
    output tagPkg::tagT                issueTagA,
    output tagPkg::tagT                issueTagB,
    output logic [`DATA_WIDTH-1:0]     issueDataA,
    output logic [`DATA_WIDTH-1:0]     issueDataB
);
    import isaPkg::*;
    import tagPkg::*;

    opcodeT                     op;
    logic                       memOp;
    logic                       storeOp;
    logic [`REG_NAME_WIDTH-1:0] destReg;
    logic                       poolFree;
    logic                       accept;
    tagT                        destTag;
    logic                       hitA;
    logic                       hitB;
    tagT                        operandTagA;
    tagT                        operandTagB;
    logic [`DATA_WIDTH-1:0]     operandDataA;
    logic [`DATA_WIDTH-1:0]     operandDataB;

    function automatic logic cdbHit(tagT tag, logic valid, tagT busTag);
        return valid && (tag != NO_TAG) && (tag == busTag);
    endfunction

    assign op = instrWord.aluView.op;
    assign memOp = isMemOp(op);
    assign storeOp = (op == OP_STORE);

    // operand A is the base and B the store data for memory ops
    always_comb begin
        if (memOp) begin
            readNameA = instrWord.memView.baseReg;
            readNameB = storeOp ? instrWord.memView.dataReg : '0;
            destReg = storeOp ? '0 : instrWord.memView.dataReg;
        end else begin
            readNameA = instrWord.aluView.rs1;
            readNameB = instrWord.aluView.rs2;
            destReg = instrWord.aluView.rd;
        end
    end

    assign poolFree = memOp ? lsFreeValid : aluFreeValid;
    assign destTag = memOp ? lsFreeTag : aluFreeTag;

    assign stall = instrValid && !poolFree;
    assign accept = instrValid && poolFree;

    assign aluAlloc = accept && !memOp;
    assign lsAlloc = accept && memOp;

    // stores and writes to r0 leave the table alone
    assign renameEn = accept && !storeOp && (destReg != '0);
    assign renameReg = destReg;
    assign renameTag = destTag;

    // bypass a result that is on the bus this cycle
    assign hitA = cdbHit(readTagA, cdbValid, cdbTag);
    assign hitB = cdbHit(readTagB, cdbValid, cdbTag);
    assign operandTagA = hitA ? NO_TAG : readTagA;
    assign operandTagB = hitB ? NO_TAG : readTagB;
    assign operandDataA = hitA ? cdbData : readDataA;
    assign operandDataB = hitB ? cdbData : readDataB;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            aluIssue <= 1'b0;
            lsIssue <= 1'b0;
        end else begin
            aluIssue <= aluAlloc;
            lsIssue <= lsAlloc;
        end
    end

    // issue record, only meaningful while a strobe is high
    always_ff @(posedge clk) begin
        if (accept) begin
            issueOp <= op;
            issueTag <= destTag;
            issueTagA <= operandTagA;
            issueTagB <= operandTagB;
            issueDataA <= operandDataA;
            issueDataB <= operandDataB;
        end
    end

endmodule

/* logic/renameTable.sv */
`timescale 1ns/1ns
`include "dispatch_params.svh"

module renameTable (
    input  logic                       clk,
    input  logic                       rstN,

    input  logic [`REG_NAME_WIDTH-1:0] readNameA,
    input  logic [`REG_NAME_WIDTH-1:0] readNameB,
    output tagPkg::tagT                readTagA,
    output tagPkg::tagT                readTagB,
    output logic [`DATA_WIDTH-1:0]     readDataA,
    output logic [`DATA_WIDTH-1:0]     readDataB,

    input  logic                       renameEn,
    input  logic [`REG_NAME_WIDTH-1:0] renameReg,
    input  tagPkg::tagT                renameTag,

    input  logic                       cdbValid,
    input  tagPkg::tagT                cdbTag,
    input  logic [`DATA_WIDTH-1:0]     cdbData
);
    import tagPkg::*;

    logic [`DATA_WIDTH-1:0] regValue [`REG_COUNT];
    tagT                    regTag   [`REG_COUNT];

    logic cdbLive;

    // a zero tag on the bus never matches a present value
    assign cdbLive = cdbValid && (cdbTag != NO_TAG);

    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int r = 0; r < `REG_COUNT; r++) begin
                regValue[r] <= '0;
                regTag[r] <= NO_TAG;
            end
        end else begin
            // r0 is never written, so it stays zero with no tag
            for (int r = 1; r < `REG_COUNT; r++) begin
                if (renameEn && (int'(renameReg) == r)) begin
                    // new producer takes over, a stale broadcast is ignored
                    regTag[r] <= renameTag;
                end else if (cdbLive && (regTag[r] == cdbTag)) begin
                    regValue[r] <= cdbData;
                    regTag[r] <= NO_TAG;
                end
            end
        end
    end

    // asynchronous read ports
    assign readTagA = regTag[readNameA];
    assign readTagB = regTag[readNameB];
    assign readDataA = regValue[readNameA];
    assign readDataB = regValue[readNameB];

endmodule

/* logic/slotPool.sv */
`timescale 1ns/1ns

module slotPool #(
    parameter int          entryCount = 4,
    parameter tagPkg::tagT tagBase    = tagPkg::ALU_TAG_BASE
) (
    input  logic        clk,
    input  logic        rstN,
    input  logic        alloc,
    input  logic        releaseEn,
    input  tagPkg::tagT releaseTag,
    output logic        freeValid,
    output tagPkg::tagT freeTag
);
    import tagPkg::*;

    localparam int IDX_W = (entryCount > 1) ? $clog2(entryCount) : 1;

    logic [entryCount-1:0] busy;
    logic [IDX_W-1:0]      freeIdx;
    tagT                   relOffset;

    // lowest free entry wins, so scan downward and keep the last hit
    always_comb begin
        freeValid = 1'b0;
        freeIdx = '0;
        for (int i = entryCount - 1; i >= 0; i--) begin
            if (!busy[i]) begin
                freeValid = 1'b1;
                freeIdx = IDX_W'(i);
            end
        end
    end

    assign freeTag = tagBase + tagT'(freeIdx);

    // entry index of the tag being released
    assign relOffset = releaseTag - tagBase;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            busy <= '0;
        end else begin
            if (alloc && freeValid) begin
                busy[freeIdx] <= 1'b1;
            end
            if (releaseEn) begin
                busy[relOffset[IDX_W-1:0]] <= 1'b0;
            end
        end
    end

endmodule

/* logic/tagPkg.sv */
`include "dispatch_params.svh"

package tagPkg;

    typedef logic [`TAG_WIDTH-1:0] tagT;

    // value is present, nothing to wait for
    localparam tagT NO_TAG = '0;

    // alu entries 1..8
    localparam tagT ALU_TAG_BASE = 4'd1;
    localparam tagT ALU_TAG_LAST = ALU_TAG_BASE + tagT'(`RS_ALU_SIZE - 1);

    // load/store entries 9..12
    localparam tagT LS_TAG_BASE = 4'd9;
    localparam tagT LS_TAG_LAST = LS_TAG_BASE + tagT'(`RS_LS_SIZE - 1);

endpackage

/* logic/isaPkg.sv */
`include "dispatch_params.svh"

package isaPkg;

    typedef enum logic [3:0] {
        OP_ADD   = 4'h0,
        OP_SUB   = 4'h1,
        OP_AND   = 4'h2,
        OP_OR    = 4'h3,
        OP_XOR   = 4'h4,
        OP_LOAD  = 4'h8,
        OP_STORE = 4'h9
    } opcodeT;

    // register-register format
    typedef struct packed {
        opcodeT                     op;
        logic [`REG_NAME_WIDTH-1:0] rd;
        logic [`REG_NAME_WIDTH-1:0] rs1;
        logic [`REG_NAME_WIDTH-1:0] rs2;
        logic [12:0]                unused;
    } aluViewT;

    // dataReg is the load destination or the store source
    typedef struct packed {
        opcodeT                     op;
        logic [`REG_NAME_WIDTH-1:0] dataReg;
        logic [`REG_NAME_WIDTH-1:0] baseReg;
        logic [17:0]                offset;
    } memViewT;

    // both views share the opcode in the top nibble
    typedef union packed {
        aluViewT aluView;
        memViewT memView;
    } instrWordT;

    function automatic logic isMemOp(opcodeT op);
        return (op == OP_LOAD) || (op == OP_STORE);
    endfunction

endpackage

/* include/dispatch_params.svh */
`ifndef DISPATCH_PARAMS_SVH
`define DISPATCH_PARAMS_SVH

// station sizes
`define RS_ALU_SIZE 8
`define RS_LS_SIZE 4

// architectural state
`define REG_COUNT 32
`define REG_NAME_WIDTH 5

// datapath widths
`define DATA_WIDTH 32
`define TAG_WIDTH 4

`endif
